/* common/snd_params.svh */
//********************************************************************
// sound board constants, shared by the cpu, glue and tone blocks
// the sample divider counts cen_tone strobes and must be at least 2
//********************************************************************

`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// cpu program counter reset value, start of the rom window
`define SND_ROM_BASE   16'h8000

// work ram address width, 2K by 8
`define SND_RAM_AW     11

// cen_tone strobes per output sample
`define SND_SAMPLE_DIV 8

// amplitude byte to 16-bit sample
`define SND_AMP_SHIFT  7

`endif

/* common/snd_pkg.sv */
//********************************************************************
// shared types of the sound board
// opcodes outside opcode_e run as no-operation in the cpu
//********************************************************************

package snd_pkg;

    // sound cpu sequencer
    typedef enum logic [2:0] {
        FETCH,      // opcode byte
        OPER_LO,    // first operand byte
        OPER_HI,    // second operand byte
        EXEC,       // single data access
        WAIT_IRQ    // parked until the latch irq
    } cpu_state_e;

    // accumulator machine opcodes
    typedef enum logic [7:0] {
        LDI = 8'h01,  // acc = imm
        LDA = 8'h02,  // acc = mem[addr16]
        STA = 8'h03,  // mem[addr16] = acc
        XRI = 8'h04,  // acc ^= imm
        JMP = 8'h05,  // pc = addr16
        WAI = 8'h06   // wait for irq_pend
    } opcode_e;

    // cpu address map regions
    typedef enum logic [2:0] {
        REG_ROM,    // a15 set
        REG_RAM,    // a14..a11 = 0
        REG_LATCH,  // a14..a11 = 2, main cpu latch
        REG_TONE,   // a14..a11 = 5, write only
        REG_NONE    // unmapped, reads ff
    } region_e;

endpackage

/* common/snd_bus_if.sv */
//********************************************************************
// sound cpu bus, one access at a time
// an access ends on the clock where step is high, no other handshake
//********************************************************************

interface snd_bus_if;

    logic [15:0] addr;   // cpu address
    logic [ 7:0] wdata;  // store data
    logic        we;     // write strobe, held for the whole access
    logic [ 7:0] rdata;  // read data from the glue mux
    logic        step;   // bus cycle completes

    modport cpu (
        output addr,
        output wdata,
        output we,
        input  rdata,
        input  step
    );

    modport glue (
        input  addr,
        input  wdata,
        input  we,
        output rdata,
        output step
    );

endinterface

/* hw/snd_cpu/snd_cpu.sv */
//********************************************************************
// small accumulator cpu in place of the 6809 with little endian operands
// advances only on bus.step so rom wait and cen pacing come from glue
// snd_rstb holds only this block in reset
//********************************************************************

`include "snd_params.svh"

module snd_cpu (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   snd_rstb,   // active low reset from the main cpu
    input  logic   irq_pend,   // edge latched in the glue
    snd_bus_if.cpu bus
);
    import snd_pkg::*;

    cpu_state_e  state;
    logic [15:0] pc;
    logic [15:0] opr;       // address operand of LDA/STA/JMP
    logic [ 7:0] acc;
    opcode_e     op;
    opcode_e     fetch_op;  // opcode byte as seen on the bus
    logic        cpu_rst;

    assign cpu_rst  = !rst_n || !snd_rstb;
    assign fetch_op = opcode_e'(bus.rdata);

    // only EXEC puts a data address on the bus
    assign bus.addr  = (state == EXEC) ? opr : pc;
    assign bus.wdata = acc;
    assign bus.we    = (state == EXEC) && (op == STA);

    // sequencer and program counter
    always_ff @(posedge clk) begin
        if (cpu_rst) begin
            state <= FETCH;
            pc    <= `SND_ROM_BASE;
        end else if (bus.step) begin
            case (state)
                FETCH: begin
                    pc <= pc + 16'd1;
                    case (fetch_op)
                        LDI, XRI, LDA, STA, JMP: state <= OPER_LO;
                        WAI:                     state <= WAIT_IRQ;
                        default:                 state <= FETCH;  // nop
                    endcase
                end
                OPER_LO: begin
                    pc <= pc + 16'd1;
                    // immediates finish here
                    if (op == LDI || op == XRI) begin
                        state <= FETCH;
                    end else begin
                        state <= OPER_HI;
                    end
                end
                OPER_HI: begin
                    if (op == JMP) begin
                        pc    <= {bus.rdata, opr[7:0]};  // target complete
                        state <= FETCH;
                    end else begin
                        pc    <= pc + 16'd1;
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    state <= FETCH;  // load or store done
                end
                WAIT_IRQ: begin
                    if (irq_pend) begin
                        state <= FETCH;  // pc already past WAI
                    end
                end
                default: begin
                    state <= FETCH;
                end
            endcase
        end
    end

    // accumulator, opcode and operand registers
    always_ff @(posedge clk) begin
        if (cpu_rst) begin
            op  <= opcode_e'(8'h00);
            opr <= 16'h0000;
            acc <= 8'h00;
        end else if (bus.step) begin
            case (state)
                FETCH: begin
                    op <= fetch_op;
                end
                OPER_LO: begin
                    opr[7:0] <= bus.rdata;
                    if (op == LDI) begin
                        acc <= bus.rdata;
                    end else if (op == XRI) begin
                        acc <= acc ^ bus.rdata;
                    end
                end
                OPER_HI: begin
                    opr[15:8] <= bus.rdata;
                end
                EXEC: begin
                    if (op == LDA) begin
                        acc <= bus.rdata;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // program must never store into the rom window
    a_no_rom_write: assert property (
        @(posedge clk) disable iff (cpu_rst)
        bus.we |-> !bus.addr[15]
    ) else $error("sound cpu store to rom address %h", bus.addr);

endmodule

/* hw/snd_glue/snd_glue.sv */
//********************************************************************
// board glue: address decode, read mux, rom wait, irq latch, work ram
// step waits on rom_ok without limit while rom is selected
// tone registers are write only, reads there return ff
//********************************************************************

`include "snd_params.svh"

module snd_glue (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen_cpu,      // cpu bus pacing strobe
    input  logic        snd_irq,      // from main cpu, edge counts
    input  logic [ 7:0] snd_latch,
    input  logic        rom_ok,
    input  logic [ 7:0] rom_data,
    output logic [14:0] rom_addr,
    output logic        rom_cs,
    output logic        irq_pend,
    output logic        tone_we,
    output logic [ 1:0] tone_sel,
    output logic [ 7:0] tone_wdata,
    snd_bus_if.glue     bus
);
    import snd_pkg::*;

    region_e    region;
    logic       ram_cs;
    logic       latch_cs;
    logic       tone_cs;
    logic       ram_we;
    logic [7:0] ram_q;
    logic       irq_d;      // snd_irq one clock back
    logic       irq_edge;
    logic       irq_clr;

    logic [7:0] ram [0:(1 << `SND_RAM_AW) - 1];

    // address decode
    always_comb begin
        if (bus.addr[15]) begin
            region = REG_ROM;
        end else begin
            case (bus.addr[14:11])
                4'd0:    region = REG_RAM;
                4'd2:    region = REG_LATCH;
                4'd5:    region = REG_TONE;
                default: region = REG_NONE;  // old adpcm slot included
            endcase
        end
    end

    assign rom_cs   = (region == REG_ROM);
    assign ram_cs   = (region == REG_RAM);
    assign latch_cs = (region == REG_LATCH);
    assign tone_cs  = (region == REG_TONE);
    assign rom_addr = bus.addr[14:0];

    // cpu stalls while rom data is not ready
    assign bus.step = cen_cpu && !(rom_cs && !rom_ok);

    // read mux
    always_comb begin
        case (region)
            REG_ROM:   bus.rdata = rom_data;
            REG_RAM:   bus.rdata = ram_q;
            REG_LATCH: bus.rdata = snd_latch;
            default:   bus.rdata = 8'hff;  // tone and unmapped
        endcase
    end

    // work ram, async read so data is valid in the step cycle
    assign ram_we = bus.step && bus.we && ram_cs;
    assign ram_q  = ram[bus.addr[`SND_RAM_AW-1:0]];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[bus.addr[`SND_RAM_AW-1:0]] <= bus.wdata;
        end
    end

    // tone register port, lands one clock after step
    assign tone_we    = bus.step && bus.we && tone_cs;
    assign tone_sel   = bus.addr[1:0];
    assign tone_wdata = bus.wdata;

    // irq latch, set by rising edge, cleared by the latch read
    assign irq_edge = snd_irq && !irq_d;
    assign irq_clr  = bus.step && latch_cs && !bus.we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_d    <= 1'b0;
            irq_pend <= 1'b0;
        end else begin
            irq_d    <= snd_irq;
            irq_pend <= irq_edge || (irq_pend && !irq_clr);  // new edge wins
        end
    end

    // decode sanity
    a_one_cs: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({rom_cs, ram_cs, latch_cs, tone_cs})
    ) else $error("more than one sound chip select");

    // the cpu must never run faster than cen_cpu
    a_step_cen: assert property (
        @(posedge clk) disable iff (!rst_n)
        !cen_cpu |-> !bus.step
    ) else $error("step without cen_cpu");

endmodule

/* hw/snd_tone/snd_tone.sv */
//********************************************************************
// two channel square wave, stands in for the fm chip
// reg 0 period, reg 1 left amp, reg 2 right amp, reg 3 ignored
// no back-pressure, one sample per SND_SAMPLE_DIV cen_tone strobes
//********************************************************************

`include "snd_params.svh"

module snd_tone (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen_tone,
    input  logic               tone_we,
    input  logic [ 1:0]        tone_sel,
    input  logic [ 7:0]        tone_wdata,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample     // one clock pulse
);
    localparam int DIV_W = $clog2(`SND_SAMPLE_DIV);

    logic [7:0]        period;
    logic [7:0]        amp_l;
    logic [7:0]        amp_r;
    logic [DIV_W-1:0]  div_cnt;
    logic [7:0]        per_cnt;
    logic              phase;
    logic              tick;      // sample due this clock
    logic signed [15:0] mag_l;
    logic signed [15:0] mag_r;

    assign tick  = cen_tone && (div_cnt == DIV_W'(`SND_SAMPLE_DIV - 1));
    assign mag_l = 16'(amp_l) << `SND_AMP_SHIFT;  // max 7f80, stays positive
    assign mag_r = 16'(amp_r) << `SND_AMP_SHIFT;

    // register file
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            period <= 8'd0;
            amp_l  <= 8'd0;
            amp_r  <= 8'd0;
        end else if (tone_we) begin
            case (tone_sel)
                2'd0:    period <= tone_wdata;
                2'd1:    amp_l  <= tone_wdata;
                2'd2:    amp_r  <= tone_wdata;
                default: begin
                end
            endcase
        end
    end

    // divider, period counter and output samples
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            per_cnt <= 8'd0;
            phase   <= 1'b0;
            sample  <= 1'b0;
            left    <= 16'sd0;
            right   <= 16'sd0;
        end else begin
            sample <= tick;
            if (cen_tone) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
            end
            if (tick) begin
                if (per_cnt == period) begin
                    per_cnt <= 8'd0;
                    phase   <= !phase;  // half wave every period+1 samples
                end else begin
                    per_cnt <= per_cnt + 8'd1;
                end
                left  <= phase ? mag_l : -mag_l;  // both channels share phase
                right <= phase ? mag_r : -mag_r;
            end
        end
    end

endmodule

/* hw/snd_board.sv */
//********************************************************************
// sound board top, cpu + glue + tone generator
// rom is external, rom_ok may hold the cpu for any number of cycles
//********************************************************************

module snd_board (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen_cpu,
    input  logic               cen_tone,
    // main cpu side
    input  logic               snd_rstb,   // cpu only reset
    input  logic               snd_irq,
    input  logic [ 7:0]        snd_latch,
    // program rom
    output logic [14:0]        rom_addr,
    output logic               rom_cs,
    input  logic [ 7:0]        rom_data,
    input  logic               rom_ok,
    // audio out
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);
    logic       irq_pend;
    logic       tone_we;
    logic [1:0] tone_sel;
    logic [7:0] tone_wdata;

    snd_bus_if bus ();

    snd_cpu u_cpu (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .snd_rstb ( snd_rstb ),
        .irq_pend ( irq_pend ),
        .bus      ( bus.cpu  )
    );

    snd_glue u_glue (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen_cpu    ( cen_cpu    ),
        .snd_irq    ( snd_irq    ),
        .snd_latch  ( snd_latch  ),
        .rom_ok     ( rom_ok     ),
        .rom_data   ( rom_data   ),
        .rom_addr   ( rom_addr   ),
        .rom_cs     ( rom_cs     ),
        .irq_pend   ( irq_pend   ),
        .tone_we    ( tone_we    ),
        .tone_sel   ( tone_sel   ),
        .tone_wdata ( tone_wdata ),
        .bus        ( bus.glue   )
    );

    snd_tone u_tone (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cen_tone   ( cen_tone   ),
        .tone_we    ( tone_we    ),
        .tone_sel   ( tone_sel   ),
        .tone_wdata ( tone_wdata ),
        .left       ( left       ),
        .right      ( right      ),
        .sample     ( sample     )
    );

endmodule

/* tb/tb_snd_board.sv */
//********************************************************************
// sound board testbench with a rom model that adds random wait states
// rom image and test records come from tb/snd_input.txt
// rom_ok drops one clock late so cen_cpu must stay 1-in-2
//********************************************************************

module tb_snd_board;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               cen_cpu = 1'b0;
    logic               cen_tone;
    logic               snd_rstb;
    logic               snd_irq;
    logic [ 7:0]        snd_latch;
    logic [14:0]        rom_addr;
    logic               rom_cs;
    logic [ 7:0]        rom_data = 8'h00;
    logic               rom_ok = 1'b0;
    logic signed [15:0] left;
    logic signed [15:0] right;
    logic               sample;

    logic [15:0] img [0:255];     // rom image followed by records
    int          rom_len;
    int          max_delay = 0;   // rom wait states of the current test
    integer      seed = 32'h64a6;
    integer      r;
    int          dly;
    int          wait_cnt = 0;
    logic        req_valid = 1'b0;
    logic [14:0] req_addr = 15'd0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          sample_cnt = 0;
    logic signed [15:0] prev_l = 16'sd0;
    logic signed [15:0] prev_r = 16'sd0;

    snd_board u_snd_board (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cen_cpu   ( cen_cpu   ),
        .cen_tone  ( cen_tone  ),
        .snd_rstb  ( snd_rstb  ),
        .snd_irq   ( snd_irq   ),
        .snd_latch ( snd_latch ),
        .rom_addr  ( rom_addr  ),
        .rom_cs    ( rom_cs    ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .left      ( left      ),
        .right     ( right     ),
        .sample    ( sample    )
    );

    always #2 clk = ~clk;

    always @(posedge clk) cen_cpu <= !cen_cpu;  // every 2nd cycle

    function automatic logic [7:0] rom_byte(input logic [14:0] a);
        if (32'(a) < rom_len) begin
            return img[32'(a) + 1][7:0];
        end
        return 8'h00;  // nop past the image
    endfunction

    function automatic logic [31:0] mag(input logic signed [15:0] x);
        logic [15:0] u;
        u = x[15] ? 16'(-x) : 16'(x);
        return {16'd0, u};
    endfunction

    function automatic string mode_name(input int m);
        case (m)
            0:       return "irq edge";
            1:       return "irq held";
            default: return "edge in snd_rstb";
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // rom with a fresh random delay per new address
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok    <= 1'b0;
            req_valid <= 1'b0;
        end else if (!req_valid || rom_addr != req_addr) begin
            r         = $random(seed);
            dly       = (r & 32'h7fffffff) % (max_delay + 1);
            req_valid <= 1'b1;
            req_addr  <= rom_addr;
            wait_cnt  <= dly;
            rom_ok    <= (dly == 0);
            rom_data  <= rom_byte(rom_addr);
        end else if (wait_cnt > 1) begin
            wait_cnt <= wait_cnt - 1;
        end else begin
            wait_cnt <= 0;
            rom_ok   <= 1'b1;  // data already on rom_data
        end
    end

    // outputs move only with sample and share one phase
    always @(negedge clk) begin
        if (rst_n) begin
            if (sample) begin
                sample_cnt++;
                if (left != 16'sd0 && right != 16'sd0) begin
                    check("sign of right vs left", 32'(right[15]), 32'(left[15]));
                end
            end else begin
                check("left without sample", 32'(left), 32'(prev_l));
                check("right without sample", 32'(right), 32'(prev_r));
            end
        end
        prev_l = left;
        prev_r = right;
    end

    task automatic report(input int id, input string what, input int err0);
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", id, what, (errors == err0) ? "pass" : "FAIL");
    endtask

    task automatic wait_update(input int id, input logic [31:0] old_r);
        int cycles;
        cycles = 0;
        @(negedge clk);
        // right is written last by the program
        while (mag(right) == old_r && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= 2000) begin
            $display("test %0d: right channel never updated within 2000 cycles", id);
            errors++;
        end
    endtask

    task automatic hold_steady(input int cycles, input logic [31:0] exp_l,
                               input logic [31:0] exp_r);
        bit moved;
        moved = 1'b0;
        for (int i = 0; i < cycles && !moved; i++) begin
            @(negedge clk);
            if (mag(left) != exp_l || mag(right) != exp_r) begin
                check("left magnitude", mag(left), exp_l);
                check("right magnitude", mag(right), exp_r);
                moved = 1'b1;  // report once
            end
        end
        @(posedge clk);  // back on the drive edge
    endtask

    task automatic reset_test();
        int start;
        int cycles;
        int err0;
        err0 = errors;
        @(negedge clk);
        check("left", 32'(left), 32'd0);
        check("right", 32'(right), 32'd0);
        check("sample", 32'(sample), 32'd0);
        check("rom_cs", 32'(rom_cs), 32'd1);  // first fetch is in rom
        check("rom_addr", 32'(rom_addr), 32'h0000);  // pc at the rom base
        start  = sample_cnt;
        cycles = 0;
        while (sample_cnt - start < 4 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= 200) begin
            $display("test 0: sample strobe did not keep pulsing after reset");
            errors++;
        end
        @(negedge clk);
        check("left", 32'(left), 32'd0);
        check("right", 32'(right), 32'd0);
        report(0, "reset", err0);
    endtask

    task automatic run_record(input int b);
        int          id;
        int          mode;
        logic [ 7:0] v;
        logic [31:0] exp_l;
        logic [31:0] exp_r;
        logic [31:0] old_l;
        logic [31:0] old_r;
        int          err0;
        id    = int'(img[b]);
        v     = img[b + 1][7:0];
        mode  = int'(img[b + 2]);
        exp_l = {16'd0, img[b + 4]};
        exp_r = {16'd0, img[b + 5]};
        err0  = errors;
        @(negedge clk);
        old_l = mag(left);
        old_r = mag(right);
        @(posedge clk);
        max_delay <= int'(img[b + 3]);
        snd_latch <= v;
        if (mode == 2) begin
            snd_rstb <= 1'b0;  // cpu held while the glue still latches the edge
        end
        @(posedge clk);
        snd_irq <= 1'b1;
        if (mode == 2) begin
            hold_steady(100, old_l, old_r);
            snd_rstb <= 1'b1;
        end else begin
            repeat (2) @(posedge clk);
        end
        if (mode != 1) begin
            snd_irq <= 1'b0;
        end
        wait_update(id, old_r);
        check("left magnitude", mag(left), exp_l);
        check("right magnitude", mag(right), exp_r);
        if (mode == 1) begin
            @(posedge clk);
            snd_latch <= v ^ 8'h5a;  // no new edge so must not be picked up
            hold_steady(400, exp_l, exp_r);
            snd_irq <= 1'b0;
        end
        repeat (60) @(posedge clk);  // let the cpu get back to WAI
        report(id, mode_name(mode), err0);
    endtask

    initial begin
        int n_rec;
        int b;
        rst_n     = 1'b0;
        cen_tone  = 1'b1;  // tone runs every cycle
        snd_rstb  = 1'b1;
        snd_irq   = 1'b0;
        snd_latch = 8'h00;
        $readmemh("tb/snd_input.txt", img);
        rom_len = int'(img[0]);
        n_rec   = int'(img[rom_len + 1]);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_test();
        if (rom_len == 0 || n_rec == 0) begin
            $display("no rom image or test records found in tb/snd_input.txt");
            errors++;
        end
        b = rom_len + 2;
        for (int i = 0; i < n_rec; i++) begin
            run_record(b);
            b += 6;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/snd_pkg.sv
common/snd_bus_if.sv
hw/snd_cpu/snd_cpu.sv
hw/snd_glue/snd_glue.sv
hw/snd_tone/snd_tone.sv
hw/snd_board.sv
tb/tb_snd_board.sv

/* run.sh */
#!/bin/sh
# build and run the sound board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_snd_board -f vlog.f

out=$(./obj_dir/Vtb_snd_board)
echo "$out"

# nonzero status unless the pass line is present
echo "$out" | grep -qx "Simulation passed"

/* tb/snd_input.txt */
// word 0: rom byte count, then the rom bytes from address 8000
// then the record count, then per record: id latch mode max_delay exp_left exp_right
// mode 0 = irq edge, 1 = irq held high, 2 = edge while snd_rstb is low
0015
06
02 00 10
03 10 00
03 01 28
02 10 00
04 ff
03 02 28
05 00 80
0004
0001 0055 0000 0000 2a80 5500
0002 003c 0000 0006 1e00 6180
0003 0081 0001 0002 4080 3f00
0004 007f 0002 0003 3f80 4000
